// File: design/pktgen_settings.svh
// register map, bus widths and pattern constants; seed reset values must keep every 23-bit slice nonzero
`ifndef PKTGEN_SETTINGS_SVH
`define PKTGEN_SETTINGS_SVH

// ------------------------------
// csr addresses
// ------------------------------
`define PKTGEN_ADDR_NUMPKTS        8'h00
`define PKTGEN_ADDR_RANDOMPAYLOAD  8'h02
`define PKTGEN_ADDR_START          8'h03  // write only, reads 0
`define PKTGEN_ADDR_STOP           8'h04
`define PKTGEN_ADDR_MACSA0         8'h05  // sa[31:0]
`define PKTGEN_ADDR_MACSA1         8'h06  // sa[47:32]
`define PKTGEN_ADDR_MACDA0         8'h07  // da[31:0]
`define PKTGEN_ADDR_MACDA1         8'h08  // da[47:32]
`define PKTGEN_ADDR_TXPKTCNT       8'h09  // read only
`define PKTGEN_ADDR_RNDSEED0       8'h0a
`define PKTGEN_ADDR_RNDSEED1       8'h0b
`define PKTGEN_ADDR_RNDSEED2       8'h0c  // 28 bits used
`define PKTGEN_ADDR_PKTLENGTH      8'h0d

// bus widths
`define PKTGEN_DATA_W  64
`define PKTGEN_CSR_W   32

// payload length clamp, bytes
`define PKTGEN_MIN_LEN  8
`define PKTGEN_MAX_LEN  1500

// incrementing pattern, bytes 00 01 02 .. then +8 per word
`define PKTGEN_INC_INIT  64'h0001020304050607
`define PKTGEN_INC_STEP  64'h0808080808080808

// seed registers after reset
`define PKTGEN_SEED0_RST  32'h1357_9bdf
`define PKTGEN_SEED1_RST  32'h2468_ace0
`define PKTGEN_SEED2_RST  32'h0abc_def1

// prbs23, x^23 + x^18 + 1
`define PKTGEN_PRBS_W    23
`define PKTGEN_PRBS_TAP  18

`endif

// File: design/pktgen_pkg.sv
// shared types of the generator; widths of the stream and csr words follow pktgen_settings.svh
`include "pktgen_settings.svh"

package pktgen_pkg;

   // ------------------------------
   // data and register words
   // ------------------------------
   typedef logic [`PKTGEN_DATA_W-1:0] word_t;      // one avalon-st beat
   typedef logic [`PKTGEN_CSR_W-1:0]  csr_t;       // csr data
   typedef logic [7:0]                csr_addr_t;  // csr address

   // frame fields
   typedef logic [47:0] mac_t;
   typedef logic [91:0] seed_t;   // four 23-bit prbs slices
   typedef logic [15:0] len_t;    // byte count
   typedef logic [2:0]  empty_t;  // unused bytes in last beat
   typedef logic [15:0] seq_t;

   // frame states
   typedef enum logic [2:0] {
      IDLE,  // waiting for start
      HDR0,  // header words being built
      HDR1,  // word 0 on the bus
      DATA,  // payload beats, last one held until taken
      GAP    // one idle beat between frames
   } fsm_e;

endpackage

// File: design/pktgen_csr.sv
// single-cycle read and write strobes with no wait states; readdata valid one cycle after read
`include "pktgen_settings.svh"

module pktgen_csr (
   input  logic                  clk,
   input  logic                  reset,
   input  pktgen_pkg::csr_addr_t address,
   input  logic                  write,
   input  logic                  read,
   input  pktgen_pkg::csr_t      writedata,
   input  pktgen_pkg::csr_t      tx_pkt_count,   // from sequencer
   output pktgen_pkg::csr_t      readdata,
   output logic                  start,          // one-cycle pulse
   output logic                  stop,
   output pktgen_pkg::csr_t      num_packets,
   output pktgen_pkg::len_t      pkt_len,        // already clamped
   output logic                  random_payload,
   output pktgen_pkg::mac_t      mac_da,
   output pktgen_pkg::mac_t      mac_sa,
   output pktgen_pkg::seed_t     seed
);

   logic [31:0] macsa0_q, macda0_q;
   logic [15:0] macsa1_q, macda1_q;
   logic [31:0] seed0_q, seed1_q;
   logic [27:0] seed2_q;

   // limit a written length to the legal payload range
   function automatic pktgen_pkg::len_t clamp_len(input pktgen_pkg::csr_t v);
      if (v < `PKTGEN_MIN_LEN)
         return pktgen_pkg::len_t'(`PKTGEN_MIN_LEN);
      else if (v > `PKTGEN_MAX_LEN)
         return pktgen_pkg::len_t'(`PKTGEN_MAX_LEN);
      else
         return v[15:0];
   endfunction

   // ------------------------------
   // register writes
   // ------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         num_packets    <= '0;
         pkt_len        <= pktgen_pkg::len_t'(`PKTGEN_MIN_LEN);
         random_payload <= 1'b0;
         start          <= 1'b0;
         stop           <= 1'b0;
         macsa0_q       <= '0;
         macsa1_q       <= '0;
         macda0_q       <= '0;
         macda1_q       <= '0;
         seed0_q        <= `PKTGEN_SEED0_RST;         // nonzero so prbs never locks up
         seed1_q        <= `PKTGEN_SEED1_RST;
         seed2_q        <= 28'(`PKTGEN_SEED2_RST);
      end else begin
         start <= write && (address == `PKTGEN_ADDR_START) && writedata[0];  // self clearing
         if (write) begin
            case (address)
               `PKTGEN_ADDR_NUMPKTS:       num_packets    <= writedata;
               `PKTGEN_ADDR_RANDOMPAYLOAD: random_payload <= writedata[0];
               `PKTGEN_ADDR_STOP:          stop           <= writedata[0];
               `PKTGEN_ADDR_MACSA0:        macsa0_q       <= writedata;
               `PKTGEN_ADDR_MACSA1:        macsa1_q       <= writedata[15:0];
               `PKTGEN_ADDR_MACDA0:        macda0_q       <= writedata;
               `PKTGEN_ADDR_MACDA1:        macda1_q       <= writedata[15:0];
               `PKTGEN_ADDR_RNDSEED0:      seed0_q        <= writedata;
               `PKTGEN_ADDR_RNDSEED1:      seed1_q        <= writedata;
               `PKTGEN_ADDR_RNDSEED2:      seed2_q        <= writedata[27:0];
               `PKTGEN_ADDR_PKTLENGTH:     pkt_len        <= clamp_len(writedata);
               default: ;                                  // start handled above
            endcase
         end
      end
   end

   assign mac_sa = {macsa1_q, macsa0_q};
   assign mac_da = {macda1_q, macda0_q};
   assign seed   = {seed2_q, seed1_q, seed0_q};        // slice 0 in the low bits

   // ------------------------------
   // registered read mux
   // ------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (read) begin
         case (address)
            `PKTGEN_ADDR_NUMPKTS:       readdata <= num_packets;
            `PKTGEN_ADDR_RANDOMPAYLOAD: readdata <= {31'h0, random_payload};
            `PKTGEN_ADDR_STOP:          readdata <= {31'h0, stop};
            `PKTGEN_ADDR_MACSA0:        readdata <= macsa0_q;
            `PKTGEN_ADDR_MACSA1:        readdata <= {16'h0, macsa1_q};
            `PKTGEN_ADDR_MACDA0:        readdata <= macda0_q;
            `PKTGEN_ADDR_MACDA1:        readdata <= {16'h0, macda1_q};
            `PKTGEN_ADDR_TXPKTCNT:      readdata <= tx_pkt_count;
            `PKTGEN_ADDR_RNDSEED0:      readdata <= seed0_q;
            `PKTGEN_ADDR_RNDSEED1:      readdata <= seed1_q;
            `PKTGEN_ADDR_RNDSEED2:      readdata <= {4'h0, seed2_q};
            `PKTGEN_ADDR_PKTLENGTH:     readdata <= {16'h0, pkt_len};
            default:                    readdata <= '0;     // start and holes
         endcase
      end
   end

endmodule

// File: design/pkt_header_gen.sv
// builds the two ethernet header beats; words are sampled on hdr_load and held until the next one
module pkt_header_gen (
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  logic              hdr_load,
   input  logic              pkt_done,
   input  pktgen_pkg::mac_t  mac_da,
   input  pktgen_pkg::mac_t  mac_sa,
   input  pktgen_pkg::len_t  pkt_len,
   output pktgen_pkg::word_t hdr_word0,
   output pktgen_pkg::word_t hdr_word1
);

   pktgen_pkg::seq_t seq_q;
   pktgen_pkg::seq_t seq_nxt;

   // hdr_load may share a cycle with start or pkt_done,
   // so the words take the value the counter is about to hold
   always_comb begin
      if (start)
         seq_nxt = '0;
      else if (pkt_done)
         seq_nxt = seq_q + 16'd1;
      else
         seq_nxt = seq_q;
   end

   // ------------------------------
   // sequence number
   // ------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         seq_q <= '0;
      else
         seq_q <= seq_nxt;
   end

   // header beats
   always_ff @(posedge clk) begin
      if (hdr_load) begin
         hdr_word0 <= {mac_da, mac_sa[47:32]};           // da, sa hi
         hdr_word1 <= {mac_sa[31:0], pkt_len, seq_nxt};  // sa lo, length, seq
      end
   end

endmodule

// File: design/payload_gen.sv
// incrementing or four side-by-side prbs23 payload beats; a beat changes only on payload_adv
`include "pktgen_settings.svh"

module payload_gen (
   input  logic              clk,
   input  logic              reset,
   input  logic              payload_load,    // start of a run
   input  logic              payload_adv,     // beat taken
   input  logic              random_payload,  // 1 = prbs
   input  pktgen_pkg::seed_t seed,
   output pktgen_pkg::word_t payload_word
);

   localparam int W  = `PKTGEN_PRBS_W;
   localparam int NG = 4;                                 // generators

   localparam pktgen_pkg::seed_t SEED_RST =
      {28'(`PKTGEN_SEED2_RST), `PKTGEN_SEED1_RST, `PKTGEN_SEED0_RST};

   pktgen_pkg::word_t inc_q;
   logic [W-1:0]      prbs_q [NG];
   logic [NG*W-1:0]   prbs_cat;

   // one advance is W single right shifts with bit tap ^ bit 0 into the msb
   function automatic logic [W-1:0] prbs_adv(input logic [W-1:0] s);
      logic [W-1:0] r;
      r = s;
      for (int i = 0; i < W; i++) begin
         r = {r[`PKTGEN_PRBS_TAP] ^ r[0], r[W-1:1]};
      end
      return r;
   endfunction

   // ------------------------------
   // incrementing counter
   // ------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         inc_q <= `PKTGEN_INC_INIT;
      else if (payload_load)
         inc_q <= `PKTGEN_INC_INIT;
      else if (payload_adv)
         inc_q <= inc_q + `PKTGEN_INC_STEP;               // wraps at 64 bits
   end

   // ------------------------------
   // prbs generators
   // ------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int g = 0; g < NG; g++) begin
            prbs_q[g] <= SEED_RST[g*W +: W];
         end
      end else if (payload_load) begin
         for (int g = 0; g < NG; g++) begin
            prbs_q[g] <= seed[g*W +: W];                  // low slice to generator 0
         end
      end else if (payload_adv) begin
         for (int g = 0; g < NG; g++) begin
            prbs_q[g] <= prbs_adv(prbs_q[g]);
         end
      end
   end

   assign prbs_cat = {prbs_q[3], prbs_q[2], prbs_q[1], prbs_q[0]};

   // generator 0 in the low bits and the top 28 bits dropped
   assign payload_word = random_payload ? prbs_cat[63:0] : inc_q;

endmodule

// File: design/frame_sequencer.sv
// frame fsm and avalon-st source, ready latency 0; everything but the start pickup waits for tx_ready
module frame_sequencer (
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  logic              stop,
   input  pktgen_pkg::csr_t  num_packets,   // 0 means one packet
   input  pktgen_pkg::len_t  pkt_len,
   input  pktgen_pkg::word_t hdr_word0,
   input  pktgen_pkg::word_t hdr_word1,
   input  pktgen_pkg::word_t payload_word,
   input  logic              tx_ready,
   output logic              hdr_load,
   output logic              payload_load,
   output logic              payload_adv,
   output logic              pkt_done,
   output pktgen_pkg::csr_t  tx_pkt_count,
   output pktgen_pkg::word_t tx_data,
   output logic              tx_valid,
   output logic              tx_sop,
   output logic              tx_eop,
   output pktgen_pkg::empty_t tx_empty
);

   pktgen_pkg::fsm_e state_q, state_nxt;
   pktgen_pkg::len_t rem_q;      // payload bytes not yet put on the bus
   logic             load_hdr0;  // header word 0 into the output register
   logic             load_hdr1;
   logic             last_beat;
   logic             run_done;

   assign last_beat = (rem_q <= 16'd8);
   assign run_done  = stop || (tx_pkt_count >= num_packets);

   // ------------------------------
   // next state and strobes
   // ------------------------------
   always_comb begin
      state_nxt    = state_q;
      hdr_load     = 1'b0;
      payload_load = 1'b0;
      payload_adv  = 1'b0;
      pkt_done     = 1'b0;
      load_hdr0    = 1'b0;
      load_hdr1    = 1'b0;
      case (state_q)
         pktgen_pkg::IDLE: begin
            if (start) begin                       // taken even with tx_ready low
               hdr_load     = 1'b1;
               payload_load = 1'b1;
               state_nxt    = pktgen_pkg::HDR0;
            end
         end
         pktgen_pkg::HDR0: begin
            if (tx_ready) begin
               load_hdr0 = 1'b1;
               state_nxt = pktgen_pkg::HDR1;
            end
         end
         pktgen_pkg::HDR1: begin
            if (tx_ready) begin                    // word 0 accepted
               load_hdr1 = 1'b1;
               state_nxt = pktgen_pkg::DATA;
            end
         end
         pktgen_pkg::DATA: begin
            if (tx_ready && tx_eop) begin          // eop beat accepted
               pkt_done  = 1'b1;
               hdr_load  = 1'b1;                   // next header ready for gap
               state_nxt = pktgen_pkg::GAP;
            end else if (tx_ready) begin
               payload_adv = 1'b1;
            end
         end
         pktgen_pkg::GAP: begin
            if (run_done) begin
               state_nxt = pktgen_pkg::IDLE;
            end else if (tx_ready) begin
               load_hdr0 = 1'b1;                   // straight into the next frame
               state_nxt = pktgen_pkg::HDR1;
            end
         end
         default: state_nxt = pktgen_pkg::IDLE;
      endcase
   end

   // ------------------------------
   // state, flags, counters
   // ------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state_q      <= pktgen_pkg::IDLE;
         tx_valid     <= 1'b0;
         tx_sop       <= 1'b0;
         tx_eop       <= 1'b0;
         tx_empty     <= '0;
         rem_q        <= '0;
         tx_pkt_count <= '0;
      end else begin
         state_q <= state_nxt;
         if (load_hdr0) begin
            tx_valid <= 1'b1;
            tx_sop   <= 1'b1;
            tx_eop   <= 1'b0;
            tx_empty <= '0;
            rem_q    <= pkt_len;                   // length sampled per frame
         end else if (load_hdr1) begin
            tx_sop <= 1'b0;
         end else if (payload_adv) begin
            tx_eop   <= last_beat;
            tx_empty <= last_beat ? pktgen_pkg::empty_t'(3'd0 - rem_q[2:0]) : '0;
            rem_q    <= rem_q - 16'd8;
         end else if (pkt_done) begin
            tx_valid <= 1'b0;                      // gap beat
            tx_eop   <= 1'b0;
            tx_empty <= '0;
         end
         if (start)
            tx_pkt_count <= '0;
         else if (pkt_done)
            tx_pkt_count <= tx_pkt_count + 32'd1;
      end
   end

   // output data register, no reset
   always_ff @(posedge clk) begin
      if (load_hdr0)
         tx_data <= hdr_word0;
      else if (load_hdr1)
         tx_data <= hdr_word1;
      else if (payload_adv)
         tx_data <= payload_word;
   end

endmodule

// File: design/pktgen_top.sv
// ethernet test frame generator top; fcs is left to the downstream mac, single clock domain
module pktgen_top (
   input  logic                  clk,
   input  logic                  reset,
   // csr bus
   input  pktgen_pkg::csr_addr_t address,
   input  logic                  write,
   input  logic                  read,
   input  pktgen_pkg::csr_t      writedata,
   output pktgen_pkg::csr_t      readdata,
   // avalon-st source
   input  logic                  tx_ready,
   output pktgen_pkg::word_t     tx_data,
   output logic                  tx_valid,
   output logic                  tx_sop,
   output logic                  tx_eop,
   output pktgen_pkg::empty_t    tx_empty
);

   // ------------------------------
   // csr to datapath
   // ------------------------------
   logic              start, stop, random_payload;
   pktgen_pkg::csr_t  num_packets, tx_pkt_count;
   pktgen_pkg::len_t  pkt_len;
   pktgen_pkg::mac_t  mac_da, mac_sa;
   pktgen_pkg::seed_t seed;

   // sequencer to word sources
   logic              hdr_load, payload_load, payload_adv, pkt_done;
   pktgen_pkg::word_t hdr_word0, hdr_word1, payload_word;

   pktgen_csr i_pktgen_csr (
      .clk, .reset, .address, .write, .read, .writedata, .tx_pkt_count,
      .readdata, .start, .stop, .num_packets, .pkt_len, .random_payload,
      .mac_da, .mac_sa, .seed
   );

   pkt_header_gen i_pkt_header_gen (
      .clk, .reset, .start, .hdr_load, .pkt_done,
      .mac_da, .mac_sa, .pkt_len,
      .hdr_word0, .hdr_word1
   );

   payload_gen i_payload_gen (
      .clk, .reset, .payload_load, .payload_adv, .random_payload, .seed,
      .payload_word
   );

   frame_sequencer i_frame_sequencer (
      .clk, .reset, .start, .stop, .num_packets, .pkt_len,
      .hdr_word0, .hdr_word1, .payload_word, .tx_ready,
      .hdr_load, .payload_load, .payload_adv, .pkt_done, .tx_pkt_count,
      .tx_data, .tx_valid, .tx_sop, .tx_eop, .tx_empty
   );

endmodule

// File: verif/tb_pktgen_tests.svh
// directed tests, included inside tb_pktgen; each leaves the generator idle with stop clear

   task automatic set_run(input int packets, input int len, input logic rnd);
      csr_write(`PKTGEN_ADDR_NUMPKTS, 32'(packets));
      csr_write(`PKTGEN_ADDR_PKTLENGTH, 32'(len));
      csr_write(`PKTGEN_ADDR_RANDOMPAYLOAD, {31'h0, rnd});
   endtask

   task automatic set_macs(input pktgen_pkg::mac_t da, input pktgen_pkg::mac_t sa);
      csr_write(`PKTGEN_ADDR_MACDA0, da[31:0]);
      csr_write(`PKTGEN_ADDR_MACDA1, {16'h0, da[47:32]});
      csr_write(`PKTGEN_ADDR_MACSA0, sa[31:0]);
      csr_write(`PKTGEN_ADDR_MACSA1, {16'h0, sa[47:32]});
      mac_da_v = da;
      mac_sa_v = sa;
   endtask

   // ------------------------------
   // register bank
   // ------------------------------
   task automatic csr_readback();
      begin_test();
      csr_expect(`PKTGEN_ADDR_TXPKTCNT, 32'h0, "readdata TXPKTCNT");
      csr_write(`PKTGEN_ADDR_NUMPKTS, 32'h1234_5678);
      csr_expect(`PKTGEN_ADDR_NUMPKTS, 32'h1234_5678, "readdata NUMPKTS");
      csr_write(`PKTGEN_ADDR_RANDOMPAYLOAD, 32'h1);
      csr_expect(`PKTGEN_ADDR_RANDOMPAYLOAD, 32'h1, "readdata RANDOMPAYLOAD");
      csr_write(`PKTGEN_ADDR_RANDOMPAYLOAD, 32'h0);
      csr_write(`PKTGEN_ADDR_STOP, 32'h1);
      csr_expect(`PKTGEN_ADDR_STOP, 32'h1, "readdata STOP");
      csr_write(`PKTGEN_ADDR_STOP, 32'h0);
      csr_expect(`PKTGEN_ADDR_STOP, 32'h0, "readdata STOP");
      csr_write(`PKTGEN_ADDR_MACSA0, 32'hdead_beef);
      csr_write(`PKTGEN_ADDR_MACSA1, 32'hffff_0a0b);     // only bits 47:32 kept
      csr_write(`PKTGEN_ADDR_MACDA0, 32'h0bad_f00d);
      csr_write(`PKTGEN_ADDR_MACDA1, 32'h5a5a_c0de);
      csr_expect(`PKTGEN_ADDR_MACSA0, 32'hdead_beef, "readdata MACSA0");
      csr_expect(`PKTGEN_ADDR_MACSA1, 32'h0000_0a0b, "readdata MACSA1");
      csr_expect(`PKTGEN_ADDR_MACDA0, 32'h0bad_f00d, "readdata MACDA0");
      csr_expect(`PKTGEN_ADDR_MACDA1, 32'h0000_c0de, "readdata MACDA1");
      csr_write(`PKTGEN_ADDR_RNDSEED0, 32'hcafe_f00d);
      csr_write(`PKTGEN_ADDR_RNDSEED1, 32'h0bad_1dea);
      csr_write(`PKTGEN_ADDR_RNDSEED2, 32'h0765_4321);   // fits the 28 seed bits
      csr_expect(`PKTGEN_ADDR_RNDSEED0, 32'hcafe_f00d, "readdata RNDSEED0");
      csr_expect(`PKTGEN_ADDR_RNDSEED1, 32'h0bad_1dea, "readdata RNDSEED1");
      csr_expect(`PKTGEN_ADDR_RNDSEED2, 32'h0765_4321, "readdata RNDSEED2");
      csr_write(`PKTGEN_ADDR_PKTLENGTH, 32'd3);          // below the minimum
      csr_expect(`PKTGEN_ADDR_PKTLENGTH, 32'd8, "readdata PKTLENGTH");
      csr_write(`PKTGEN_ADDR_PKTLENGTH, 32'd4000);       // above the maximum
      csr_expect(`PKTGEN_ADDR_PKTLENGTH, 32'd1500, "readdata PKTLENGTH");
      csr_write(`PKTGEN_ADDR_PKTLENGTH, 32'd100);
      csr_expect(`PKTGEN_ADDR_PKTLENGTH, 32'd100, "readdata PKTLENGTH");
      csr_expect(`PKTGEN_ADDR_START, 32'h0, "readdata START");
      csr_expect(8'h01, 32'h0, "readdata unmapped 0x01");
      csr_expect(8'h0e, 32'h0, "readdata unmapped 0x0e");
      end_test("csr readback");
   endtask

   // ------------------------------
   // frame tests
   // ------------------------------
   task automatic single_frame();
      begin_test();
      set_macs(48'h0010_9400_0002, 48'h0010_9400_0001);
      set_run(1, 21, 1'b0);
      build_expected(1, 21, 1'b0);
      start_run();
      wait_cycles(2);
      check("tx_valid", 64'(tx_valid), 64'h0);          // start still in flight
      wait_cycles(1);
      check("tx_valid", 64'(tx_valid), 64'h1);          // second edge after the write
      check("tx_sop", 64'(tx_sop), 64'h1);
      wait_eops(1);
      compare_stream();
      end_test("single frame, incrementing payload");
   endtask

   task automatic multi_packet();
      begin_test();
      set_run(3, 16, 1'b0);
      build_expected(3, 16, 1'b0);
      start_run();
      wait_eops(3);
      compare_stream();                                  // also catches a fourth frame
      csr_expect(`PKTGEN_ADDR_TXPKTCNT, 32'd3, "readdata TXPKTCNT");
      end_test("multi-packet run");
   endtask

   task automatic prbs_payload();
      begin_test();
      csr_write(`PKTGEN_ADDR_RNDSEED0, 32'h9e37_79b9);
      csr_write(`PKTGEN_ADDR_RNDSEED1, 32'h7f4a_7c15);
      csr_write(`PKTGEN_ADDR_RNDSEED2, 32'h0516_2b3c);
      seed_v = {28'h516_2b3c, 32'h7f4a_7c15, 32'h9e37_79b9};
      set_run(0, 40, 1'b1);                              // 0 packets still sends one
      build_expected(1, 40, 1'b1);
      start_run();
      wait_eops(1);
      compare_stream();
      csr_write(`PKTGEN_ADDR_RANDOMPAYLOAD, 32'h0);
      end_test("random payload");
   endtask

   task automatic back_pressure();
      begin_test();
      set_run(3, 16, 1'b0);
      build_expected(3, 16, 1'b0);
      random_ready <= 1'b1;
      start_run();
      wait_eops(3);
      random_ready <= 1'b0;
      compare_stream();
      csr_expect(`PKTGEN_ADDR_TXPKTCNT, 32'd3, "readdata TXPKTCNT");
      end_test("back-pressure");
   endtask

   task automatic stop_mid_run();
      begin_test();
      set_run(100, 64, 1'b0);
      build_expected(1, 64, 1'b0);
      start_run();
      while (cap_data.size() <= cap_base)               // first beat taken
         @(posedge clk);
      csr_write(`PKTGEN_ADDR_STOP, 32'h1);               // lands well before the eop
      wait_eops(1);
      compare_stream();
      csr_expect(`PKTGEN_ADDR_TXPKTCNT, 32'd1, "readdata TXPKTCNT");
      csr_write(`PKTGEN_ADDR_STOP, 32'h0);
      end_test("stop");
   endtask

// File: verif/tb_pktgen.sv
// directed testbench for pktgen_top; tx_ready is random only while random_ready is set
`include "pktgen_settings.svh"

module tb_pktgen;

   localparam int FRAME_WORDS = 5 + 12 + 7 + 12 + 10;     // beats sent by the frame tests
   localparam int MAX_CYCLES  = FRAME_WORDS * 4 + 800;    // margin for csr traffic and settling
   localparam int SETTLE      = 16;                       // idle cycles to catch an extra frame

   logic                  clk;
   logic                  reset;
   pktgen_pkg::csr_addr_t address;
   logic                  write;
   logic                  read;
   pktgen_pkg::csr_t      writedata;
   pktgen_pkg::csr_t      readdata;
   logic                  tx_ready;
   pktgen_pkg::word_t     tx_data;
   logic                  tx_valid;
   logic                  tx_sop;
   logic                  tx_eop;
   pktgen_pkg::empty_t    tx_empty;

   // ------------------------------
   // captured and expected beats
   // ------------------------------
   pktgen_pkg::word_t  cap_data[$];                        // kept across runs
   logic               cap_sop[$];
   logic               cap_eop[$];
   pktgen_pkg::empty_t cap_empty[$];
   pktgen_pkg::word_t  exp_data[$];
   logic               exp_sop[$];
   logic               exp_eop[$];
   pktgen_pkg::empty_t exp_empty[$];

   int                cap_base;                            // first beat of the current run
   int                error_count;
   int                test_count;
   int                tests_failed;
   int                errors_at_start;
   logic              random_ready;
   pktgen_pkg::mac_t  mac_da_v;                            // values last programmed
   pktgen_pkg::mac_t  mac_sa_v;
   pktgen_pkg::seed_t seed_v;

   pktgen_top i_pktgen_top (
      .clk, .reset, .address, .write, .read, .writedata, .readdata,
      .tx_ready, .tx_data, .tx_valid, .tx_sop, .tx_eop, .tx_empty
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // right-shift galois lfsr for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      else
         return s >> 1;
   endfunction

   // tx_ready takes one lfsr bit per cycle while random_ready is set
   initial begin
      logic [31:0] lfsr;
      lfsr = 32'hc5bc_c3b5;
      tx_ready <= 1'b1;
      forever begin
         @(posedge clk);
         if (random_ready) begin
            tx_ready <= lfsr[0];
            lfsr = lfsr_step(lfsr);
         end else begin
            tx_ready <= 1'b1;
         end
      end
   end

   // record every accepted beat with the pre-edge values the DUT saw
   always @(posedge clk) begin
      if (tx_valid && tx_ready) begin
         cap_data.push_back(tx_data);
         cap_sop.push_back(tx_sop);
         cap_eop.push_back(tx_eop);
         cap_empty.push_back(tx_empty);
      end
   end

   // watchdog
   initial begin
      int cycles;
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("watchdog stopped the run after %0d cycles", cycles);
      $display("Test failures found");
      $finish;
   end

   // ------------------------------
   // checking and bookkeeping
   // ------------------------------
   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         error_count++;
         $display("Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      error_count++;
      $display("failure: %s", what);
   endtask

   task automatic begin_test();
      errors_at_start = error_count;
   endtask

   task automatic end_test(input string name);
      test_count++;
      if (error_count == errors_at_start) begin
         $display("%s: pass", name);
      end else begin
         tests_failed++;
         $display("%s: FAIL, %0d errors", name, error_count - errors_at_start);
      end
   endtask

   // ------------------------------
   // csr bus
   // ------------------------------
   task automatic csr_write(input pktgen_pkg::csr_addr_t a, input pktgen_pkg::csr_t d);
      @(posedge clk);
      address   <= a;
      writedata <= d;
      write     <= 1'b1;
      @(posedge clk);                                      // register loads here
      write     <= 1'b0;
   endtask

   task automatic csr_expect(input pktgen_pkg::csr_addr_t a, input pktgen_pkg::csr_t exp,
                             input string name);
      @(posedge clk);
      address <= a;
      read    <= 1'b1;
      @(posedge clk);
      read    <= 1'b0;
      @(posedge clk);                                      // readdata one cycle after the strobe
      check(name, 64'(readdata), 64'(exp));
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   function automatic int eops_seen();
      int n;
      n = 0;
      for (int i = cap_base; i < cap_eop.size(); i++)
         if (cap_eop[i])
            n++;
      return n;
   endfunction

   // wait for n end-of-packet beats in this run, then idle to catch extra beats
   task automatic wait_eops(input int n);
      while (eops_seen() < n)
         @(posedge clk);
      wait_cycles(SETTLE);
   endtask

   task automatic start_run();
      cap_base = cap_data.size();
      csr_write(`PKTGEN_ADDR_START, 32'h1);
   endtask

   // ------------------------------
   // reference model
   // ------------------------------
   // 23 single right shifts with bit 18 ^ bit 0 into bit 22
   function automatic logic [22:0] prbs_advance(input logic [22:0] s);
      logic [22:0] r;
      logic        fb;
      r = s;
      for (int i = 0; i < 23; i++) begin
         fb    = r[18] ^ r[0];
         r     = r >> 1;
         r[22] = fb;
      end
      return r;
   endfunction

   function automatic void add_expected(input pktgen_pkg::word_t d, input logic sop,
                                        input logic eop, input pktgen_pkg::empty_t e);
      exp_data.push_back(d);
      exp_sop.push_back(sop);
      exp_eop.push_back(eop);
      exp_empty.push_back(e);
   endfunction

   // expected beats of a whole run with the pattern running on across frames
   task automatic build_expected(input int frames, input int len, input logic rnd);
      pktgen_pkg::word_t inc;
      logic [22:0]       gen[4];
      logic [91:0]       cat;
      int                words;
      exp_data.delete();
      exp_sop.delete();
      exp_eop.delete();
      exp_empty.delete();
      inc   = `PKTGEN_INC_INIT;
      words = (len + 7) / 8;
      for (int g = 0; g < 4; g++)
         gen[g] = seed_v[g*23 +: 23];                      // low slice to generator 0
      for (int f = 0; f < frames; f++) begin
         add_expected({mac_da_v, mac_sa_v[47:32]}, 1'b1, 1'b0, 3'd0);
         add_expected({mac_sa_v[31:0], 16'(len), 16'(f)}, 1'b0, 1'b0, 3'd0);  // seq = frame
         for (int w = 0; w < words; w++) begin
            cat = {gen[3], gen[2], gen[1], gen[0]};
            add_expected(rnd ? cat[63:0] : inc, 1'b0, w == words - 1,
                         (w == words - 1) ? 3'((8 - len % 8) % 8) : 3'd0);
            inc = inc + `PKTGEN_INC_STEP;
            for (int g = 0; g < 4; g++)
               gen[g] = prbs_advance(gen[g]);
         end
      end
   endtask

   task automatic compare_stream();
      int n;
      n = cap_data.size() - cap_base;
      if (n != exp_data.size())
         report_failure($sformatf("%0d beats accepted, %0d expected", n, exp_data.size()));
      if (n > 0 && !cap_eop[cap_data.size() - 1])
         report_failure("stream ended without an end of packet");
      for (int i = 0; i < n && i < exp_data.size(); i++) begin
         check($sformatf("tx_data[%0d]", i), cap_data[cap_base + i], exp_data[i]);
         check($sformatf("tx_sop[%0d]", i), 64'(cap_sop[cap_base + i]), 64'(exp_sop[i]));
         check($sformatf("tx_eop[%0d]", i), 64'(cap_eop[cap_base + i]), 64'(exp_eop[i]));
         check($sformatf("tx_empty[%0d]", i), 64'(cap_empty[cap_base + i]),
               64'(exp_empty[i]));
      end
   endtask

   `include "tb_pktgen_tests.svh"

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      address      <= '0;
      writedata    <= '0;
      write        <= 1'b0;
      read         <= 1'b0;
      reset        <= 1'b1;
      random_ready = 1'b0;
      error_count  = 0;
      test_count   = 0;
      tests_failed = 0;
      cap_base     = 0;
      seed_v       = '0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      csr_readback();
      single_frame();
      multi_packet();
      prbs_payload();
      back_pressure();
      stop_mid_run();
      wait_cycles(2);
      $display("%0d tests, %0d failed, %0d errors", test_count, tests_failed, error_count);
      if (error_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// File: pktgen.f
+incdir+design
+incdir+verif
design/pktgen_pkg.sv
design/pktgen_csr.sv
design/pkt_header_gen.sv
design/payload_gen.sv
design/frame_sequencer.sv
design/pktgen_top.sv
verif/tb_pktgen.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_pktgen

verilator --binary --timing -Wno-fatal -j 0 --top-module tb_pktgen \
  -f pktgen.f -o "$BIN" --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0
